// ==== source/alu_consts.svh ====
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width of the datapath
`define ALU_WIDTH 32

// opcode field width for eight operations
`define ALU_OP_WIDTH 3

// result queue entries
// the producer also starts with this many request credits
`define ALU_QUEUE_DEPTH 4

// width of the queue occupancy and downstream credit counters
`define ALU_CREDIT_WIDTH 3

`endif

// ==== source/aluPkg.sv ====
`include "alu_consts.svh"

package aluPkg;

  // opcode encoding of the ALU command table
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    opAdd  = 3'd0,
    opSub  = 3'd1,
    opXor  = 3'd2,
    opSlt  = 3'd3,
    opAnd  = 3'd4,
    opNand = 3'd5,
    opNor  = 3'd6,
    opOr   = 3'd7
  } aluOpE;

  // result mux select where NOR reuses the AND path and NAND the OR path
  typedef enum logic [2:0] {
    selAdd = 3'd0,
    selXor = 3'd1,
    selSlt = 3'd2,
    selAnd = 3'd3,
    selOr  = 3'd4
  } aluSelE;

  typedef struct packed {
    aluOpE                 op;
    logic [`ALU_WIDTH-1:0] operandA;
    logic [`ALU_WIDTH-1:0] operandB;
  } aluReqS;

  typedef struct packed {
    aluSelE sel;
    logic   invertA;
    logic   invertB;
    logic   carryIn;         // also selects subtract in the adder
    logic   enableOverflow;
  } aluCtrlS;

  typedef struct packed {
    logic [`ALU_WIDTH-1:0] result;
    logic                  carryout;
    logic                  overflow;
    logic                  zero;
  } aluRspS;

endpackage

// ==== source/aluControlDecode.sv ====
`include "alu_consts.svh"

module aluControlDecode import aluPkg::*; (
  input  aluOpE   op,
  output aluCtrlS ctrl
);

  always_comb begin
    // defaults give a plain add with no inversion
    ctrl.sel            = selAdd;
    ctrl.invertA        = 1'b0;
    ctrl.invertB        = 1'b0;
    ctrl.carryIn        = 1'b0;
    ctrl.enableOverflow = 1'b1;

    case (op)
      opAdd: begin
        ctrl.sel = selAdd;
      end
      opSub: begin
        ctrl.sel     = selAdd;
        ctrl.carryIn = 1'b1;   // A + ~B + 1
      end
      opXor: begin
        ctrl.sel = selXor;
      end
      opSlt: begin
        ctrl.sel            = selSlt;
        ctrl.invertB        = 1'b1;
        ctrl.carryIn        = 1'b1;
        ctrl.enableOverflow = 1'b0;  // compare only without an overflow report
      end
      opAnd: begin
        ctrl.sel = selAnd;
      end
      opNand: begin
        ctrl.sel     = selOr;  // ~A | ~B
        ctrl.invertA = 1'b1;
        ctrl.invertB = 1'b1;
      end
      opNor: begin
        ctrl.sel     = selAnd; // ~A & ~B
        ctrl.invertA = 1'b1;
        ctrl.invertB = 1'b1;
      end
      opOr: begin
        ctrl.sel = selOr;
      end
      default: begin
        ctrl.sel = selAdd;
      end
    endcase
  end

endmodule

// ==== source/rippleAdder.sv ====
`include "alu_consts.svh"

module rippleAdder (
  input  logic [`ALU_WIDTH-1:0] operandA,
  input  logic [`ALU_WIDTH-1:0] operandB,
  input  logic                  carryIn,
  output logic [`ALU_WIDTH-1:0] sum,
  output logic                  carryout,
  output logic                  overflow
);

  localparam int Width = `ALU_WIDTH;

  logic [Width:0]   carry;      // carry[i] feeds bit i
  logic [Width-1:0] bFlip;      // B after conditional inversion

  assign carry[0] = carryIn;    // +1 completes the two's complement

  genvar i;
  generate
    for (i = 0; i < Width; i = i + 1) begin : genFullAdder
      logic aXorB;

      // subtract when carryIn is set
      assign bFlip[i] = operandB[i] ^ carryIn;
      assign aXorB    = operandA[i] ^ bFlip[i];
      assign sum[i]   = aXorB ^ carry[i];
      // generate or propagate
      assign carry[i+1] = (operandA[i] & bFlip[i]) | (aXorB & carry[i]);
    end
  endgenerate

  assign carryout = carry[Width];

  // signed overflow when carries into and out of the msb differ
  assign overflow = carry[Width] ^ carry[Width-1];

endmodule

// ==== source/aluCore.sv ====
`include "alu_consts.svh"

module aluCore import aluPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   reqValid,
  input  aluReqS req,
  output logic   coreValid,
  output aluRspS coreRsp
);

  localparam int Width = `ALU_WIDTH;

  aluCtrlS          ctrl;
  logic [Width-1:0] flipA;
  logic [Width-1:0] flipB;
  logic [Width-1:0] andResult;
  logic [Width-1:0] orResult;
  logic [Width-1:0] xorResult;
  logic [Width-1:0] addResult;
  logic [Width-1:0] sltResult;
  logic [Width-1:0] result;
  logic             adderCarry;
  logic             adderOverflow;
  logic             useAdder;
  logic             carryFlag;
  logic             overflowFlag;
  logic             zeroFlag;

  aluControlDecode decode0 (
    .op   (req.op),
    .ctrl (ctrl)
  );

  // inversion feeds the logic units only
  assign flipA = req.operandA ^ {Width{ctrl.invertA}};
  assign flipB = req.operandB ^ {Width{ctrl.invertB}};

  assign andResult = flipA & flipB;
  assign orResult  = flipA | flipB;
  assign xorResult = flipA ^ flipB;

  // adder inverts B itself from carryIn
  rippleAdder adder0 (
    .operandA (req.operandA),
    .operandB (req.operandB),
    .carryIn  (ctrl.carryIn),
    .sum      (addResult),
    .carryout (adderCarry),
    .overflow (adderOverflow)
  );

  // sign of A-B, corrected when the subtraction overflowed
  assign sltResult = {{(Width-1){1'b0}}, addResult[Width-1] ^ adderOverflow};

  always_comb begin
    case (ctrl.sel)
      selAdd:  result = addResult;
      selXor:  result = xorResult;
      selSlt:  result = sltResult;
      selAnd:  result = andResult;
      selOr:   result = orResult;
      default: result = addResult;
    endcase
  end

  assign useAdder = (ctrl.sel == selAdd);

  // carry is meaningful for add, sub and slt
  assign carryFlag    = adderCarry & (useAdder | (ctrl.sel == selSlt));
  assign overflowFlag = adderOverflow & ctrl.enableOverflow & useAdder;
  assign zeroFlag     = (result == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      coreValid <= 1'b0;
    end else begin
      coreValid <= reqValid;
    end
  end

  // payload only loads on a real request
  always_ff @(posedge clk) begin
    if (reqValid) begin
      coreRsp.result   <= result;
      coreRsp.carryout <= carryFlag;
      coreRsp.overflow <= overflowFlag;
      coreRsp.zero     <= zeroFlag;
    end
  end

endmodule

// ==== source/resultQueue.sv ====
`include "alu_consts.svh"

module resultQueue import aluPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   coreValid,
  input  aluRspS coreRsp,
  input  logic   rspCredit,
  output logic   rspValid,
  output aluRspS rsp,
  output logic   reqCredit
);

  localparam int Depth = `ALU_QUEUE_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = `ALU_CREDIT_WIDTH;
  localparam logic [PtrW-1:0] LastIdx = PtrW'(Depth - 1);

  aluRspS          mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;     // entries held
  logic [CntW-1:0] credits;   // downstream slots granted to us
  logic            pop;

  // only entries already counted can leave, so a write waits one edge
  assign pop = (count != '0) && (credits != '0);

  always_ff @(posedge clk) begin
    if (coreValid) begin
      mem[wrPtr] <= coreRsp;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (coreValid) begin
        wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({coreValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;    // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= '0;
    end else begin
      case ({rspCredit, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // registered pop stage
  always_ff @(posedge clk) begin
    if (rst) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rsp <= mem[rdPtr];
    end
  end

  // slot freed as the response leaves
  assign reqCredit = rspValid;

endmodule

// ==== source/aluExecUnit.sv ====
`include "alu_consts.svh"

module aluExecUnit import aluPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   reqValid,
  input  aluReqS req,
  output logic   reqCredit,
  input  logic   rspCredit,
  output logic   rspValid,
  output aluRspS rsp
);

  logic   coreValid;
  aluRspS coreRsp;

  // one cycle compute stage
  aluCore core0 (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .req       (req),
    .coreValid (coreValid),
    .coreRsp   (coreRsp)
  );

  // holds results until the consumer grants credit
  resultQueue queue0 (
    .clk       (clk),
    .rst       (rst),
    .coreValid (coreValid),
    .coreRsp   (coreRsp),
    .rspCredit (rspCredit),
    .rspValid  (rspValid),
    .rsp       (rsp),
    .reqCredit (reqCredit)
  );

endmodule

// ==== tb/aluChecker.sv ====
`include "alu_consts.svh"

module aluChecker import aluPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   reqValid,
  input  aluReqS req,
  input  logic   reqCredit,
  input  logic   rspCredit,
  input  logic   rspValid,
  input  aluRspS rsp,
  input  logic   endCheck,
  output int     valueErrors,
  output int     protocolErrors,
  output int     pendingCount,
  output int     responsesChecked,
  output bit     checkDone
);

  localparam int Width = `ALU_WIDTH;

  aluReqS expQ[$];          // accepted requests with the oldest first
  aluReqS head;             // request being answered
  aluRspS expRsp;
  int     valErr      = 0;
  int     protoErr    = 0;
  int     issued      = 0;
  int     creditsSeen = 0;
  int     rspSeen     = 0;
  int     heldCredits = 0;  // consumer credits the unit still holds

  // expected response straight from the opcode rules
  function automatic aluRspS expectRsp(input aluReqS r);
    logic [Width:0] wide;
    aluRspS         e;
    e = '0;
    case (r.op)
      opAdd: begin
        wide       = {1'b0, r.operandA} + {1'b0, r.operandB};
        e.result   = wide[Width-1:0];
        e.carryout = wide[Width];
        e.overflow = (r.operandA[Width-1] == r.operandB[Width-1]) &&
                     (e.result[Width-1] != r.operandA[Width-1]);
      end
      opSub: begin
        e.result   = r.operandA - r.operandB;
        e.carryout = (r.operandA >= r.operandB);  // carry set means no borrow
        e.overflow = (r.operandA[Width-1] != r.operandB[Width-1]) &&
                     (e.result[Width-1] != r.operandA[Width-1]);
      end
      opSlt: begin
        e.result   = {{(Width-1){1'b0}}, ($signed(r.operandA) < $signed(r.operandB))};
        e.carryout = (r.operandA >= r.operandB);
      end
      opXor:   e.result = r.operandA ^ r.operandB;
      opAnd:   e.result = r.operandA & r.operandB;
      opNand:  e.result = ~(r.operandA & r.operandB);
      opNor:   e.result = ~(r.operandA | r.operandB);
      opOr:    e.result = r.operandA | r.operandB;
      default: e.result = '0;
    endcase
    e.zero = (e.result == '0);
    return e;
  endfunction

  task automatic compareWord(input string name, input logic [Width-1:0] expVal,
                             input logic [Width-1:0] gotVal);
    if (expVal !== gotVal) begin
      valErr++;
      $display("Fail %s expected %h got %h (op %0d a %h b %h) at %0t",
               name, expVal, gotVal, head.op, head.operandA, head.operandB, $time);
    end
  endtask

  task automatic compareBit(input string name, input logic expVal, input logic gotVal);
    if (expVal !== gotVal) begin
      valErr++;
      $display("Fail %s expected %h got %h (op %0d a %h b %h) at %0t",
               name, expVal, gotVal, head.op, head.operandA, head.operandB, $time);
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if ($isunknown({rspValid, reqCredit})) begin
        protoErr++;
        $display("rspValid or reqCredit is unknown at %0t", $time);
      end
      // responses before requests since a request from this edge cannot be answered yet
      if (rspValid === 1'b1) begin
        rspSeen++;
        if (heldCredits == 0) begin
          protoErr++;
          $display("rspValid at %0t while the unit held no consumer credit", $time);
        end else begin
          heldCredits--;
        end
        if (expQ.size() == 0) begin
          protoErr++;
          $display("rspValid at %0t with no request waiting for a response", $time);
        end else begin
          head   = expQ.pop_front();
          expRsp = expectRsp(head);
          compareWord("rsp.result", expRsp.result, rsp.result);
          compareBit("rsp.carryout", expRsp.carryout, rsp.carryout);
          compareBit("rsp.overflow", expRsp.overflow, rsp.overflow);
          compareBit("rsp.zero", expRsp.zero, rsp.zero);
        end
      end
      if (rspCredit === 1'b1) begin
        heldCredits++;
      end
      if (reqCredit === 1'b1) begin
        creditsSeen++;
        if (creditsSeen > issued) begin
          protoErr++;
          $display("reqCredit at %0t returned more credits than requests issued", $time);
        end
      end
      if (reqValid === 1'b1) begin
        expQ.push_back(req);
        issued++;
      end
      if (endCheck && !checkDone) begin
        if (expQ.size() != 0) begin
          protoErr++;
          $display("%0d requests were never answered", expQ.size());
        end
        if (creditsSeen != rspSeen) begin
          protoErr++;
          $display("%0d request credits returned for %0d responses", creditsSeen, rspSeen);
        end
        checkDone <= 1'b1;
      end
    end
    valueErrors      <= valErr;
    protocolErrors   <= protoErr;
    pendingCount     <= expQ.size();
    responsesChecked <= rspSeen;
  end

endmodule

// ==== tb/aluExecTb.sv ====
`include "alu_consts.svh"

module aluExecTb import aluPkg::*; ();

  localparam int ClkPeriod   = 8;
  localparam int Depth       = `ALU_QUEUE_DEPTH;
  localparam int NumDirected = 18;
  localparam int NumRandom   = 26;
  localparam int NumTests    = NumDirected + NumRandom;
  localparam int StallCycles = 24;
  localparam int DrainCycles = 16 * Depth;

  logic   clk;
  logic   rst;
  logic   reqValid;
  aluReqS req;
  logic   reqCredit;
  logic   rspCredit;
  logic   rspValid;
  aluRspS rsp;
  logic   endCheck;
  logic   releaseCredits;   // consumer starts granting once set
  int     valueErrors;
  int     protocolErrors;
  int     pendingCount;
  int     responsesChecked;
  bit     checkDone;

  aluReqS stim [NumTests];
  integer seed = 32'h27d4f0bd;
  int     prodCredits;      // request credits held by the producer
  int     grantedCredits;   // consumer credits not yet used by the unit
  int     drainCount;       // cycles spent waiting for the last responses

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  aluExecUnit dut0 (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .req       (req),
    .reqCredit (reqCredit),
    .rspCredit (rspCredit),
    .rspValid  (rspValid),
    .rsp       (rsp)
  );

  aluChecker chk0 (
    .clk              (clk),
    .rst              (rst),
    .reqValid         (reqValid),
    .req              (req),
    .reqCredit        (reqCredit),
    .rspCredit        (rspCredit),
    .rspValid         (rspValid),
    .rsp              (rsp),
    .endCheck         (endCheck),
    .valueErrors      (valueErrors),
    .protocolErrors   (protocolErrors),
    .pendingCount     (pendingCount),
    .responsesChecked (responsesChecked),
    .checkDone        (checkDone)
  );

  task automatic setEntry(input int idx, input aluOpE op, input logic [31:0] a,
                          input logic [31:0] b);
    stim[idx] = '{op: op, operandA: a, operandB: b};
  endtask

  task automatic loadTable();
    logic [31:0] rndOp;
    logic [31:0] rndA;
    logic [31:0] rndB;
    setEntry(0, opAdd, 32'h7fffffff, 32'h00000001);   // signed overflow
    setEntry(1, opSub, 32'h80000000, 32'h00000001);   // signed overflow
    setEntry(2, opAdd, 32'hffffffff, 32'h00000001);   // carry and zero
    setEntry(3, opSub, 32'h12345678, 32'h12345678);   // equal operands
    setEntry(4, opSub, 32'h00000005, 32'h00000007);   // borrow
    setEntry(5, opSlt, 32'hffffffff, 32'h00000001);
    setEntry(6, opSlt, 32'h00000001, 32'hffffffff);
    setEntry(7, opSlt, 32'h80000000, 32'h7fffffff);   // compare across overflow
    setEntry(8, opSlt, 32'h7fffffff, 32'h80000000);
    setEntry(9, opSlt, 32'h00000005, 32'h00000005);
    setEntry(10, opAnd, 32'hf0f0f0f0, 32'h0f0f0f0f);  // disjoint masks
    setEntry(11, opOr, 32'hf0f0f0f0, 32'h0f0f0f0f);
    setEntry(12, opXor, 32'ha5a5a5a5, 32'hffff0000);
    setEntry(13, opNand, 32'hffffffff, 32'hffffffff);
    setEntry(14, opNor, 32'h00000000, 32'h00000000);
    setEntry(15, opNor, 32'h12345678, 32'h0f0f0000);
    setEntry(16, opNand, 32'h00000000, 32'h00000003);
    setEntry(17, opXor, 32'hdeadbeef, 32'hdeadbeef);
    for (int k = NumDirected; k < NumTests; k++) begin
      rndOp = $random(seed);
      rndA  = $random(seed);
      rndB  = $random(seed);
      if (rndOp[5:4] == 2'b00) begin
        rndB = rndA;   // equal operands now and then
      end
      setEntry(k, aluOpE'(rndOp[2:0]), rndA, rndB);
    end
  endtask

  // issue only while holding a credit and stall once the queue is full
  task automatic issueAll();
    int idx;
    idx = 0;
    while (idx < NumTests) begin
      @(posedge clk);
      if (reqCredit === 1'b1) begin
        prodCredits++;
      end
      if (idx == Depth && !releaseCredits) begin
        reqValid <= 1'b0;
        repeat (StallCycles) begin
          @(posedge clk);
          if (reqCredit === 1'b1) begin
            prodCredits++;
          end
        end
        releaseCredits <= 1'b1;
      end else if (prodCredits > 0) begin
        reqValid <= 1'b1;
        req      <= stim[idx];
        prodCredits--;
        idx++;
      end else begin
        reqValid <= 1'b0;
      end
    end
    @(posedge clk);
    reqValid <= 1'b0;
  endtask

  task automatic printSummary();
    $display("errors: %0d value, %0d protocol; %0d responses checked, %0d pending",
             valueErrors, protocolErrors, responsesChecked, pendingCount);
  endtask

  initial begin
    rst            <= 1'b1;
    reqValid       <= 1'b0;
    req            <= '0;
    endCheck       <= 1'b0;
    releaseCredits <= 1'b0;
    prodCredits = Depth;
    loadTable();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (6) @(posedge clk);   // quiet period before traffic
    issueAll();
    @(posedge clk);
    drainCount = 0;
    while (pendingCount != 0 && drainCount < DrainCycles) begin
      @(posedge clk);
      drainCount++;
    end
    endCheck <= 1'b1;
    while (!checkDone) begin
      @(posedge clk);
    end
    printSummary();
    if (valueErrors + protocolErrors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // consumer with a small buffer and random credit pacing
  initial begin
    logic [31:0] rnd;
    rspCredit <= 1'b0;
    grantedCredits = 0;
    forever begin
      @(posedge clk);
      if (rspValid === 1'b1) begin
        grantedCredits--;
      end
      rnd = $random(seed);
      if (releaseCredits && grantedCredits < Depth && rnd[0]) begin
        rspCredit <= 1'b1;
        grantedCredits++;
      end else begin
        rspCredit <= 1'b0;
      end
    end
  end

  initial begin
    #((NumTests + 20) * 16 * ClkPeriod);
    $display("timeout: run did not finish within %0d clock periods", (NumTests + 20) * 16);
    printSummary();
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
source/aluPkg.sv
source/aluControlDecode.sv
source/rippleAdder.sv
source/aluCore.sv
source/resultQueue.sv
source/aluExecUnit.sv
tb/aluChecker.sv
tb/aluExecTb.sv

// ==== Makefile ====
TOP = aluExecTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -sv -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -sv -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
